/* common/vstu_pkg.sv */
// Vector store unit package
// Sizes, instruction request, address burst and W beat types shared by
// the queue, the operand buffer and the W packer

`default_nettype none

package vstu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Lanes feeding the store unit
  localparam int unsigned NrLanes      = 2;
  // Bytes per lane operand
  localparam int unsigned ElenBytes    = 8;
  // Bytes in one VRF word, all lanes together
  localparam int unsigned VrfWordBytes = NrLanes * ElenBytes;
  // W data bytes per beat, always the full bus
  localparam int unsigned AxiDataBytes = 8;
  // Instruction queue entries
  localparam int unsigned QueueDepth   = 4;
  // Instruction IDs in flight across the machine
  localparam int unsigned NrVInsn      = 8;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [8*ElenBytes-1:0] elen_t;
  typedef logic [$clog2(NrVInsn)-1:0] insn_id_t;
  typedef logic [15:0] vlen_t;

  // Target functional unit of a sequencer request
  typedef enum logic [1:0] {
    VfuStoreUnit = 2'd0,
    VfuLoadUnit  = 2'd1,
    VfuOther     = 2'd2
  } vfu_e;

  // Store request from the sequencer
  // vl counts elements, element bytes are 1 << vsew
  typedef struct packed {
    insn_id_t   id;
    vfu_e       vfu;
    vlen_t      vl;
    logic [1:0] vsew;
  } store_req_t;

  // Burst from the address generator, len is beats minus one
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } addr_req_t;

  typedef logic [8*AxiDataBytes-1:0] axi_w_data_t;
  typedef logic [AxiDataBytes-1:0]   axi_w_strb_t;

endpackage

`default_nettype wire

/* hw/vstu/lane_operand_buffer.sv */
// Lane operand buffer
// One fall-through slot per lane between the lanes and the W packer.
// All slots are released together when the packer acknowledges a word

`timescale 1ns/1ps
`default_nettype none

module lane_operand_buffer (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_ni,
  // Lane side
  input  wire vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0]     operand_i,
  input  wire logic            [vstu_pkg::NrLanes-1:0]     operand_valid_i,
  output      logic            [vstu_pkg::NrLanes-1:0]     operand_ready_o,
  // Packer side
  output      vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0]     operand_o,
  output      logic            [vstu_pkg::NrLanes-1:0]     operand_valid_o,
  input  wire logic                                        word_ack_i
);

  for (genvar lane = 0; lane < vstu_pkg::NrLanes; lane++) begin : gen_slot
    logic            full_q;
    vstu_pkg::elen_t data_q;

    // Empty slot takes a new operand
    assign operand_ready_o[lane] = ~full_q;

    // Held operand first, else pass the lane straight through
    assign operand_o[lane]       = full_q ? data_q : operand_i[lane];
    assign operand_valid_o[lane] = full_q | operand_valid_i[lane];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        full_q <= 1'b0;
      end else if (full_q) begin
        // Slot frees once the word is used up
        if (word_ack_i) begin
          full_q <= 1'b0;
        end
      end else if (operand_valid_i[lane] && !word_ack_i) begin
        full_q <= 1'b1;
      end
    end

    // Payload only, qualified by full_q
    always_ff @(posedge clk_i) begin
      if (!full_q && operand_valid_i[lane] && !word_ack_i) begin
        data_q <= operand_i[lane];
      end
    end
  end : gen_slot

endmodule

`default_nettype wire

/* hw/vstu/vinsn_queue.sv */
// Store instruction queue
// Circular store with accept, issue and commit pointers, the running-ID
// filter, commit on B responses and the registered done vector

`timescale 1ns/1ps
`default_nettype none

module vinsn_queue (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  // Sequencer
  input  wire vstu_pkg::store_req_t              pe_req_i,
  input  wire logic                              pe_req_valid_i,
  output      logic                              pe_req_ready_o,
  input  wire logic [vstu_pkg::NrVInsn-1:0]      pe_vinsn_running_i,
  output      logic [vstu_pkg::NrVInsn-1:0]      pe_vinsn_done_o,
  // Packer
  output      logic                              issue_valid_o,
  output      vstu_pkg::store_req_t              issue_req_o,
  input  wire logic                              issue_done_i,
  // B channel
  input  wire logic                              axi_b_valid_i,
  output      logic                              axi_b_ready_o,
  // Status
  output      logic                              store_pending_o,
  output      logic                              store_complete_o
);

  localparam int unsigned PntW = $clog2(vstu_pkg::QueueDepth);

  // Queued requests, no reset on the payload
  vstu_pkg::store_req_t queue_q [vstu_pkg::QueueDepth];

  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Entries still to issue, entries still to commit
  logic [PntW:0]   issue_cnt_q, commit_cnt_q;

  logic [vstu_pkg::NrVInsn-1:0] running_q, running_d;
  logic [vstu_pkg::NrVInsn-1:0] done_d;

  logic accept;
  logic commit;

  //////////////////////////////////////////////////////////////////////
  // Accept
  //////////////////////////////////////////////////////////////////////

  assign pe_req_ready_o = (commit_cnt_q != (PntW+1)'(vstu_pkg::QueueDepth));

  // Store requests only, and never an ID that is still running
  assign accept = pe_req_valid_i && pe_req_ready_o &&
                  (pe_req_i.vfu == vstu_pkg::VfuStoreUnit) &&
                  !running_q[pe_req_i.id];

  always_comb begin
    // Sequencer clears IDs as they retire machine-wide
    running_d = running_q & pe_vinsn_running_i;
    if (accept) begin
      running_d[pe_req_i.id] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue and commit
  //////////////////////////////////////////////////////////////////////

  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_req_o   = queue_q[issue_pnt_q];

  // B is always taken
  assign axi_b_ready_o = axi_b_valid_i;

  // Oldest entry may retire only once all its beats left.
  // A stray B is acked and dropped
  assign commit           = axi_b_valid_i && (commit_cnt_q != issue_cnt_q);
  assign store_complete_o = commit;
  assign store_pending_o  = (commit_cnt_q != '0);

  always_comb begin
    done_d = '0;
    if (commit) begin
      done_d[queue_q[commit_pnt_q].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q    <= '0;
      issue_pnt_q     <= '0;
      commit_pnt_q    <= '0;
      issue_cnt_q     <= '0;
      commit_cnt_q    <= '0;
      running_q       <= '0;
      pe_vinsn_done_o <= '0;
    end else begin
      // Depth is a power of two, pointers wrap on their own
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q     <= issue_cnt_q + accept - issue_done_i;
      commit_cnt_q    <= commit_cnt_q + accept - commit;
      running_q       <= running_d;
      pe_vinsn_done_o <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

/* hw/vstu/w_beat_packer.sv */
// W beat packer
// Builds byte-exact W beats from lane operands under address generator
// bursts, one instruction at a time, and marks burst and issue ends

`timescale 1ns/1ps
`default_nettype none

module w_beat_packer (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_ni,
  // Queue
  input  wire logic                                        issue_valid_i,
  input  wire vstu_pkg::store_req_t                        issue_req_i,
  output      logic                                        issue_done_o,
  // Operand buffer
  input  wire vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0]     operand_i,
  input  wire logic            [vstu_pkg::NrLanes-1:0]     operand_valid_i,
  output      logic                                        word_ack_o,
  // Address generator
  input  wire vstu_pkg::addr_req_t                         addrgen_req_i,
  input  wire logic                                        addrgen_req_valid_i,
  output      logic                                        addrgen_req_ready_o,
  // W channel
  output      vstu_pkg::axi_w_data_t                       axi_w_data_o,
  output      vstu_pkg::axi_w_strb_t                       axi_w_strb_o,
  output      logic                                        axi_w_last_o,
  output      logic                                        axi_w_valid_o,
  input  wire logic                                        axi_w_ready_i
);

  localparam int unsigned PntW  = $clog2(vstu_pkg::VrfWordBytes);
  localparam int unsigned OffW  = $clog2(vstu_pkg::ElenBytes);
  localparam int unsigned BeatW = $clog2(vstu_pkg::AxiDataBytes);

  // Instruction loaded into the byte counter
  logic            started_q, started_d;
  // Bytes of the instruction not yet sent
  vstu_pkg::vlen_t bytes_left_q, bytes_left_d;
  // Next byte to read in the current VRF word
  logic [PntW-1:0] vrf_pnt_q, vrf_pnt_d;
  // Beats sent so far in this burst
  logic [7:0]      beat_cnt_q, beat_cnt_d;

  vstu_pkg::vlen_t  load_bytes, cur_bytes, bytes_rem;
  logic [BeatW-1:0] lower_byte;
  logic [PntW:0]    axi_bytes, vrf_bytes, valid_bytes, vrf_pnt_next;
  logic             fire;
  logic             last_beat;

  //////////////////////////////////////////////////////////////////////
  // Byte accounting
  //////////////////////////////////////////////////////////////////////

  assign load_bytes = vstu_pkg::vlen_t'(issue_req_i.vl << issue_req_i.vsew);
  // Fresh instruction uses its full count this very cycle
  assign cur_bytes  = started_q ? bytes_left_q : load_bytes;

  // First beat of a burst starts at the address offset
  assign lower_byte = (beat_cnt_q == '0) ? addrgen_req_i.addr[BeatW-1:0] : '0;

  always_comb begin
    axi_bytes = (PntW+1)'(vstu_pkg::AxiDataBytes) - (PntW+1)'(lower_byte);
    vrf_bytes = (PntW+1)'(vstu_pkg::VrfWordBytes) - (PntW+1)'(vrf_pnt_q);
    // Smallest of beat, word and instruction room
    valid_bytes = (axi_bytes < vrf_bytes) ? axi_bytes : vrf_bytes;
    if (vstu_pkg::vlen_t'(valid_bytes) > cur_bytes) begin
      valid_bytes = (PntW+1)'(cur_bytes);
    end
  end

  assign bytes_rem    = cur_bytes - vstu_pkg::vlen_t'(valid_bytes);
  assign vrf_pnt_next = (PntW+1)'(vrf_pnt_q) + valid_bytes;

  // Valid waits on ready, so a stalled bus freezes everything
  assign fire = issue_valid_i && addrgen_req_valid_i && axi_w_ready_i &&
                (&operand_valid_i);

  assign last_beat           = (beat_cnt_q == addrgen_req_i.len);
  assign axi_w_valid_o       = fire;
  assign axi_w_last_o        = fire && last_beat;
  assign addrgen_req_ready_o = fire && last_beat;
  assign issue_done_o        = fire && (bytes_rem == '0);
  // Lanes move on at word end or instruction end
  assign word_ack_o          = fire && ((vrf_pnt_next == (PntW+1)'(vstu_pkg::VrfWordBytes)) ||
                                        (bytes_rem == '0));

  //////////////////////////////////////////////////////////////////////
  // Beat assembly
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    logic [PntW:0] rel;
    logic [PntW:0] vrf_byte;
    axi_w_data_o = '0;
    axi_w_strb_o = '0;
    for (int b = 0; b < vstu_pkg::AxiDataBytes; b++) begin
      rel      = (PntW+1)'(b) - (PntW+1)'(lower_byte);
      vrf_byte = (PntW+1)'(vrf_pnt_q) + rel;
      if (fire && (b >= int'(lower_byte)) && (rel < valid_bytes)) begin
        // Lane from the word half, offset inside the lane
        axi_w_data_o[8*b +: 8] = operand_i[vrf_byte[OffW]][8*vrf_byte[OffW-1:0] +: 8];
        axi_w_strb_o[b]        = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    started_d    = started_q;
    bytes_left_d = bytes_left_q;
    vrf_pnt_d    = vrf_pnt_q;
    beat_cnt_d   = beat_cnt_q;
    if (issue_valid_i && !started_q) begin
      started_d    = 1'b1;
      bytes_left_d = load_bytes;
    end
    if (fire) begin
      bytes_left_d = bytes_rem;
      vrf_pnt_d    = word_ack_o ? '0 : vrf_pnt_next[PntW-1:0];
      beat_cnt_d   = last_beat ? '0 : beat_cnt_q + 8'd1;
      // Next instruction reloads the counter
      if (bytes_rem == '0) begin
        started_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      bytes_left_q <= '0;
      vrf_pnt_q    <= '0;
      beat_cnt_q   <= '0;
    end else begin
      started_q    <= started_d;
      bytes_left_q <= bytes_left_d;
      vrf_pnt_q    <= vrf_pnt_d;
      beat_cnt_q   <= beat_cnt_d;
    end
  end

endmodule

`default_nettype wire

/* hw/vstu/vstu.sv */
// Vector store unit top level
// Queues store instructions, buffers lane operands and drives AXI W
// beats, then retires each store on its B response

`timescale 1ns/1ps
`default_nettype none

module vstu (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_ni,
  // Sequencer
  input  wire vstu_pkg::store_req_t                        pe_req_i,
  input  wire logic                                        pe_req_valid_i,
  output      logic                                        pe_req_ready_o,
  input  wire logic            [vstu_pkg::NrVInsn-1:0]     pe_vinsn_running_i,
  output      logic            [vstu_pkg::NrVInsn-1:0]     pe_vinsn_done_o,
  // Address generator
  input  wire vstu_pkg::addr_req_t                         addrgen_req_i,
  input  wire logic                                        addrgen_req_valid_i,
  output      logic                                        addrgen_req_ready_o,
  // Lanes
  input  wire vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0]     stu_operand_i,
  input  wire logic            [vstu_pkg::NrLanes-1:0]     stu_operand_valid_i,
  output      logic            [vstu_pkg::NrLanes-1:0]     stu_operand_ready_o,
  // AXI W
  output      vstu_pkg::axi_w_data_t                       axi_w_data_o,
  output      vstu_pkg::axi_w_strb_t                       axi_w_strb_o,
  output      logic                                        axi_w_last_o,
  output      logic                                        axi_w_valid_o,
  input  wire logic                                        axi_w_ready_i,
  // AXI B
  input  wire logic                                        axi_b_valid_i,
  output      logic                                        axi_b_ready_o,
  // Status
  output      logic                                        store_pending_o,
  output      logic                                        store_complete_o
);

  // Buffered operands toward the packer
  vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0] operand;
  logic            [vstu_pkg::NrLanes-1:0] operand_valid;
  logic                                    word_ack;

  // Queue head toward the packer
  logic                 issue_valid;
  vstu_pkg::store_req_t issue_req;
  logic                 issue_done;

  lane_operand_buffer i_lane_operand_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .operand_i       (stu_operand_i),
    .operand_valid_i (stu_operand_valid_i),
    .operand_ready_o (stu_operand_ready_o),
    .operand_o       (operand),
    .operand_valid_o (operand_valid),
    .word_ack_i      (word_ack)
  );

  vinsn_queue i_vinsn_queue (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pe_req_i           (pe_req_i),
    .pe_req_valid_i     (pe_req_valid_i),
    .pe_req_ready_o     (pe_req_ready_o),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .pe_vinsn_done_o    (pe_vinsn_done_o),
    .issue_valid_o      (issue_valid),
    .issue_req_o        (issue_req),
    .issue_done_i       (issue_done),
    .axi_b_valid_i      (axi_b_valid_i),
    .axi_b_ready_o      (axi_b_ready_o),
    .store_pending_o    (store_pending_o),
    .store_complete_o   (store_complete_o)
  );

  w_beat_packer i_w_beat_packer (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .issue_valid_i       (issue_valid),
    .issue_req_i         (issue_req),
    .issue_done_o        (issue_done),
    .operand_i           (operand),
    .operand_valid_i     (operand_valid),
    .word_ack_o          (word_ack),
    .addrgen_req_i       (addrgen_req_i),
    .addrgen_req_valid_i (addrgen_req_valid_i),
    .addrgen_req_ready_o (addrgen_req_ready_o),
    .axi_w_data_o        (axi_w_data_o),
    .axi_w_strb_o        (axi_w_strb_o),
    .axi_w_last_o        (axi_w_last_o),
    .axi_w_valid_o       (axi_w_valid_o),
    .axi_w_ready_i       (axi_w_ready_i)
  );

endmodule

`default_nettype wire

/* dv/vstu_tb.sv */
// Vector store unit testbench
// Directed tests for the request queue, W beat packing, back-pressure,
// request filtering and the B commit path

`timescale 1ns/1ps
`default_nettype none

module vstu_tb;

  // Cycles any single wait loop may take
  localparam int unsigned TimeoutCycles = 200;

  logic                                    clk_i;
  logic                                    rst_ni;
  vstu_pkg::store_req_t                    pe_req_i;
  logic                                    pe_req_valid_i;
  logic                                    pe_req_ready_o;
  logic            [vstu_pkg::NrVInsn-1:0] pe_vinsn_running_i;
  logic            [vstu_pkg::NrVInsn-1:0] pe_vinsn_done_o;
  vstu_pkg::addr_req_t                     addrgen_req_i;
  logic                                    addrgen_req_valid_i;
  logic                                    addrgen_req_ready_o;
  vstu_pkg::elen_t [vstu_pkg::NrLanes-1:0] stu_operand_i;
  logic            [vstu_pkg::NrLanes-1:0] stu_operand_valid_i;
  logic            [vstu_pkg::NrLanes-1:0] stu_operand_ready_o;
  vstu_pkg::axi_w_data_t                   axi_w_data_o;
  vstu_pkg::axi_w_strb_t                   axi_w_strb_o;
  logic                                    axi_w_last_o;
  logic                                    axi_w_valid_o;
  logic                                    axi_w_ready_i;
  logic                                    axi_b_valid_i;
  logic                                    axi_b_ready_o;
  logic                                    store_pending_o;
  logic                                    store_complete_o;

  int          value_errs;
  int          other_errs;
  logic [31:0] lfsr_q;

  vstu vstu_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pe_req_i            (pe_req_i),
    .pe_req_valid_i      (pe_req_valid_i),
    .pe_req_ready_o      (pe_req_ready_o),
    .pe_vinsn_running_i  (pe_vinsn_running_i),
    .pe_vinsn_done_o     (pe_vinsn_done_o),
    .addrgen_req_i       (addrgen_req_i),
    .addrgen_req_valid_i (addrgen_req_valid_i),
    .addrgen_req_ready_o (addrgen_req_ready_o),
    .stu_operand_i       (stu_operand_i),
    .stu_operand_valid_i (stu_operand_valid_i),
    .stu_operand_ready_o (stu_operand_ready_o),
    .axi_w_data_o        (axi_w_data_o),
    .axi_w_strb_o        (axi_w_strb_o),
    .axi_w_last_o        (axi_w_last_o),
    .axi_w_valid_o       (axi_w_valid_o),
    .axi_w_ready_i       (axi_w_ready_i),
    .axi_b_valid_i       (axi_b_valid_i),
    .axi_b_ready_o       (axi_b_ready_o),
    .store_pending_o     (store_pending_o),
    .store_complete_o    (store_complete_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Random bytes and compares
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic random_byte(output logic [7:0] value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[6:0], lfsr_q[0]};
    end
  endtask

  task automatic compare_data(input string name, input vstu_pkg::axi_w_data_t exp,
                              input vstu_pkg::axi_w_data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic strobe_check(input string name, input vstu_pkg::axi_w_strb_t exp,
                              input vstu_pkg::axi_w_strb_t act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic done_vector_check(input string name,
                                   input logic [vstu_pkg::NrVInsn-1:0] exp,
                                   input logic [vstu_pkg::NrVInsn-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic expect_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  // One-cycle request, dropped by the DUT if not taken
  task automatic send_request(input string name, input vstu_pkg::insn_id_t id,
                              input vstu_pkg::vfu_e vfu, input vstu_pkg::vlen_t vl,
                              input logic [1:0] vsew, input logic exp_ready);
    @(negedge clk_i);
    pe_req_i.id    = id;
    pe_req_i.vfu   = vfu;
    pe_req_i.vl    = vl;
    pe_req_i.vsew  = vsew;
    pe_req_valid_i = 1'b1;
    #1;
    expect_bit($sformatf("%s request %0d ready", name, id), exp_ready, pe_req_ready_o);
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
  endtask

  // Burst plus VRF words for one instruction, beats checked as they leave
  task automatic stream_store(input string name, input logic [31:0] addr, input logic [7:0] len,
                              input int nbytes, input int stall);
    logic [7:0]            vrf_q [$];
    vstu_pkg::axi_w_data_t exp_data [$];
    vstu_pkg::axi_w_strb_t exp_strb [$];
    logic                  exp_last [$];
    logic                  exp_ack [$];
    vstu_pkg::axi_w_data_t data;
    vstu_pkg::axi_w_strb_t strb;
    vstu_pkg::elen_t       op;
    logic [7:0]            value;
    int                    lane_idx [vstu_pkg::NrLanes];
    int                    nwords, k, lower, cnt, beat, cycles, acked;
    logic                  burst_done;
    nwords = (nbytes + vstu_pkg::VrfWordBytes - 1) / vstu_pkg::VrfWordBytes;
    for (int i = 0; i < nwords * vstu_pkg::VrfWordBytes; i++) begin
      random_byte(value);
      vrf_q.push_back(value);
    end
    // Expected beats, each the least of beat, word and instruction room
    k = 0;
    for (int b = 0; b <= int'(len); b++) begin
      lower = (b == 0) ? int'(addr % vstu_pkg::AxiDataBytes) : 0;
      cnt   = vstu_pkg::AxiDataBytes - lower;
      if (vstu_pkg::VrfWordBytes - (k % vstu_pkg::VrfWordBytes) < cnt) begin
        cnt = vstu_pkg::VrfWordBytes - (k % vstu_pkg::VrfWordBytes);
      end
      if (nbytes - k < cnt) begin
        cnt = nbytes - k;
      end
      data = '0;
      strb = '0;
      for (int j = 0; j < cnt; j++) begin
        data[8*(lower+j) +: 8] = vrf_q[k+j];
        strb[lower+j]          = 1'b1;
      end
      exp_data.push_back(data);
      exp_strb.push_back(strb);
      exp_last.push_back(b == int'(len));
      // Lanes freed once a word or the instruction is used up
      exp_ack.push_back(((k + cnt) % vstu_pkg::VrfWordBytes == 0) || (k + cnt == nbytes));
      k += cnt;
    end
    for (int l = 0; l < vstu_pkg::NrLanes; l++) begin
      lane_idx[l] = 0;
    end
    beat       = 0;
    cycles     = 0;
    acked      = 0;
    burst_done = 1'b0;
    while ((beat < exp_data.size() || !burst_done) && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      addrgen_req_i.addr  = addr;
      addrgen_req_i.len   = len;
      addrgen_req_valid_i = ~burst_done;
      // Bus held off for the first stall cycles
      axi_w_ready_i       = (cycles >= stall);
      for (int l = 0; l < vstu_pkg::NrLanes; l++) begin
        op = '0;
        // Lane l carries bytes 8l to 8l+7 of its VRF word
        for (int j = 0; j < vstu_pkg::ElenBytes; j++) begin
          if (lane_idx[l] < nwords) begin
            op[8*j +: 8] = vrf_q[vstu_pkg::VrfWordBytes*lane_idx[l] +
                                 vstu_pkg::ElenBytes*l + j];
          end
        end
        stu_operand_i[l]       = op;
        stu_operand_valid_i[l] = (lane_idx[l] < nwords);
      end
      #1;
      // Slot is empty unless it holds a word not yet acknowledged
      for (int l = 0; l < vstu_pkg::NrLanes; l++) begin
        expect_bit($sformatf("%s lane %0d ready", name, l), lane_idx[l] == acked,
                   stu_operand_ready_o[l]);
      end
      if (axi_w_valid_o && !axi_w_ready_i) begin
        other_errs++;
        $display("%s: W valid was raised while W ready was low", name);
      end
      if (axi_w_valid_o) begin
        if (beat < exp_data.size()) begin
          compare_data($sformatf("%s beat %0d data", name, beat), exp_data[beat], axi_w_data_o);
          strobe_check($sformatf("%s beat %0d strb", name, beat), exp_strb[beat], axi_w_strb_o);
          expect_bit($sformatf("%s beat %0d last", name, beat), exp_last[beat], axi_w_last_o);
          expect_bit($sformatf("%s beat %0d addrgen ready", name, beat), exp_last[beat],
                     addrgen_req_ready_o);
          if (exp_ack[beat]) begin
            acked++;
          end
        end else begin
          other_errs++;
          $display("%s: a W beat arrived after the burst was complete", name);
        end
        beat++;
      end
      if (addrgen_req_ready_o) begin
        burst_done = 1'b1;
      end
      // Lane operand moves when valid meets ready
      for (int l = 0; l < vstu_pkg::NrLanes; l++) begin
        if (stu_operand_valid_i[l] && stu_operand_ready_o[l]) begin
          lane_idx[l]++;
        end
      end
      cycles++;
    end
    if (beat < exp_data.size() || !burst_done) begin
      other_errs++;
      $display("%s: timed out with %0d of %0d beats seen", name, beat, exp_data.size());
    end
    @(negedge clk_i);
    addrgen_req_valid_i = 1'b0;
    axi_w_ready_i       = 1'b0;
    stu_operand_valid_i = '0;
  endtask

  // B response, then the done vector one cycle later
  task automatic answer_b(input string name, input logic exp_commit,
                          input logic [vstu_pkg::NrVInsn-1:0] exp_done);
    @(negedge clk_i);
    axi_b_valid_i = 1'b1;
    #1;
    expect_bit({name, " b ready"}, 1'b1, axi_b_ready_o);
    expect_bit({name, " complete"}, exp_commit, store_complete_o);
    @(negedge clk_i);
    axi_b_valid_i = 1'b0;
    #1;
    done_vector_check({name, " done"}, exp_done, pe_vinsn_done_o);
    expect_bit({name, " complete after"}, 1'b0, store_complete_o);
  endtask

  // Everything but an instruction offered, nothing may leave
  task automatic expect_idle(input string name, input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_i);
      addrgen_req_i.addr  = 32'h0000_4000;
      addrgen_req_i.len   = 8'd0;
      addrgen_req_valid_i = 1'b1;
      axi_w_ready_i       = 1'b1;
      stu_operand_valid_i = '1;
      #1;
      expect_bit({name, " w valid"}, 1'b0, axi_w_valid_o);
      expect_bit({name, " pending"}, 1'b0, store_pending_o);
    end
    @(negedge clk_i);
    addrgen_req_valid_i = 1'b0;
    axi_w_ready_i       = 1'b0;
    stu_operand_valid_i = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    #1;
    expect_bit("reset w valid", 1'b0, axi_w_valid_o);
    expect_bit("reset w last", 1'b0, axi_w_last_o);
    compare_data("reset w data", '0, axi_w_data_o);
    strobe_check("reset w strb", '0, axi_w_strb_o);
    expect_bit("reset addrgen ready", 1'b0, addrgen_req_ready_o);
    expect_bit("reset b ready", 1'b0, axi_b_ready_o);
    expect_bit("reset complete", 1'b0, store_complete_o);
    expect_bit("reset pending", 1'b0, store_pending_o);
    expect_bit("reset request ready", 1'b1, pe_req_ready_o);
    done_vector_check("reset done", '0, pe_vinsn_done_o);
  endtask

  // 4 elements of 8 bytes, two VRF words over four full beats
  task automatic aligned_store();
    send_request("aligned store", 3'd2, vstu_pkg::VfuStoreUnit, 16'd4, 2'd3, 1'b1);
    stream_store("aligned store", 32'h8000_0100, 8'd3, 32, 0);
    #1;
    expect_bit("aligned store pending", 1'b1, store_pending_o);
    answer_b("aligned store", 1'b1, 8'b0000_0100);
    expect_bit("aligned store pending after", 1'b0, store_pending_o);
  endtask

  // 11 bytes from offset 3, split 5 and 6
  task automatic unaligned_short_store();
    send_request("unaligned store", 3'd3, vstu_pkg::VfuStoreUnit, 16'd11, 2'd0, 1'b1);
    stream_store("unaligned store", 32'h0000_2003, 8'd1, 11, 0);
    answer_b("unaligned store", 1'b1, 8'b0000_1000);
    expect_bit("unaligned store pending after", 1'b0, store_pending_o);
  endtask

  task automatic full_queue_backpressure();
    for (int i = 1; i <= 4; i++) begin
      send_request("full queue", vstu_pkg::insn_id_t'(i), vstu_pkg::VfuStoreUnit, 16'd2, 2'd3,
                   1'b1);
    end
    // Queue is full now
    send_request("full queue", 3'd5, vstu_pkg::VfuStoreUnit, 16'd2, 2'd3, 1'b0);
    for (int i = 0; i < 4; i++) begin
      stream_store($sformatf("queued store %0d", i + 1), 32'h0000_1000 + 32'h40 * i,
                   8'd1, 16, (i == 0) ? 4 : 0);
    end
    // Oldest first
    for (int i = 1; i <= 4; i++) begin
      answer_b($sformatf("queued store %0d", i), 1'b1, 8'(1 << i));
    end
    expect_bit("queued stores pending after", 1'b0, store_pending_o);
    expect_bit("queued stores request ready", 1'b1, pe_req_ready_o);
  endtask

  task automatic request_filtering();
    @(negedge clk_i);
    pe_vinsn_running_i = 8'h80;
    send_request("filtering", 3'd7, vstu_pkg::VfuStoreUnit, 16'd1, 2'd3, 1'b1);
    stream_store("running id store", 32'h0000_3000, 8'd0, 8, 0);
    answer_b("running id store", 1'b1, 8'h80);
    // ID 7 still marked running, then a load request
    send_request("filtering", 3'd7, vstu_pkg::VfuStoreUnit, 16'd1, 2'd3, 1'b1);
    send_request("filtering", 3'd0, vstu_pkg::VfuLoadUnit, 16'd1, 2'd3, 1'b1);
    expect_idle("filtered requests", 6);
    pe_vinsn_running_i = '0;
  endtask

  task automatic stray_b_response();
    answer_b("stray b", 1'b0, '0);
    expect_bit("stray b pending", 1'b0, store_pending_o);
  endtask

  initial begin
    value_errs          = 0;
    other_errs          = 0;
    lfsr_q              = 32'h3a61_aa6a;
    rst_ni              = 1'b0;
    pe_req_i            = '0;
    pe_req_valid_i      = 1'b0;
    pe_vinsn_running_i  = '0;
    addrgen_req_i       = '0;
    addrgen_req_valid_i = 1'b0;
    stu_operand_i       = '0;
    stu_operand_valid_i = '0;
    axi_w_ready_i       = 1'b0;
    axi_b_valid_i       = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_values();
    aligned_store();
    unaligned_short_store();
    full_queue_backpressure();
    request_filtering();
    stray_b_response();
    $display("Checks done: %0d value errors, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
common/vstu_pkg.sv
hw/vstu/lane_operand_buffer.sv
hw/vstu/vinsn_queue.sv
hw/vstu/w_beat_packer.sv
hw/vstu/vstu.sv
dv/vstu_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module vstu_tb -f flist.f -Mdir obj_dir -o vstu_sim

run: compile
	./obj_dir/vstu_sim | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
